//--- hdl/cfg_sequencer.sv
// Sequencer FSM that walks the init, poll and receiver reset lists and issues I2C exec
`timescale 1ns/1ns
`include "ms7200_defs.svh"

module cfg_sequencer import ms7200_pkg::*; (
    input  logic       clk,
    input  logic       rstn_out,
    input  logic       start_pulse,
    input  logic       i2c_done,
    input  logic       freq_lock,
    output logic       i2c_exec,
    output seq_state_t cur_state,
    output cmd_index_t cur_index,
    output logic       byte_valid,
    output logic [1:0] byte_sel,
    output logic       poll_end,
    output logic       init_done
);

    seq_state_t state;
    cmd_index_t index;       // Next entry to issue
    seq_state_t act_state;   // List of the command in flight
    cmd_index_t act_index;   // Entry of the command in flight
    logic       act_last;
    logic       poll_last;

    function automatic cmd_index_t last_index(input seq_state_t s);
        case (s)
            SEQ_INIT:  return cmd_index_t'(`MS_INIT_LEN - 1);
            SEQ_RESET: return cmd_index_t'(`MS_RESET_LEN - 1);
            default:   return cmd_index_t'(`MS_POLL_LEN - 1);
        endcase
    endfunction

    assign act_last  = (act_index == last_index(act_state));
    assign poll_last = i2c_done && (act_state == SEQ_POLL) && act_last;

    assign byte_valid = i2c_done && (act_state == SEQ_POLL);
    assign byte_sel   = act_index[1:0];
    assign poll_end   = (state == SEQ_DECIDE);

    // The reset list is presented during the decide cycle so the command
    // table holds its first entry when the exec goes out
    assign cur_state = (poll_end && freq_lock) ? SEQ_RESET : state;
    assign cur_index = index;

    // ----------------------------------------------------------
    // State and list position
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            state     <= SEQ_STARTUP;
            index     <= '0;
            act_state <= SEQ_STARTUP;
            act_index <= '0;
        end else begin
            if (i2c_exec) begin
                act_state <= state;
                act_index <= index;
                if (index == last_index(state)) begin
                    index <= '0;
                end else begin
                    index <= index + 1'b1;
                end
            end
            case (state)
                SEQ_STARTUP: begin
                    if (start_pulse) state <= SEQ_INIT;
                end
                SEQ_INIT, SEQ_RESET: begin
                    // Leave on the exec of the last entry
                    if (i2c_exec && (index == last_index(state))) state <= SEQ_POLL;
                end
                SEQ_POLL: begin
                    if (poll_last) state <= SEQ_DECIDE;   // Fourth byte is in
                end
                SEQ_DECIDE: begin
                    state <= freq_lock ? SEQ_RESET : SEQ_POLL;
                end
                default: state <= SEQ_STARTUP;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Exec strobe
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            i2c_exec <= 1'b0;
        end else begin
            i2c_exec <= ((state == SEQ_STARTUP) && start_pulse)
                        || poll_end
                        || (i2c_done && !poll_last);
        end
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            init_done <= 1'b0;
        end else if (i2c_done && (act_state == SEQ_RESET) && act_last) begin
            init_done <= 1'b1;
        end
    end

endmodule

//--- hdl/cmd_table.sv
// Registered command ROM holding the init, poll and receiver reset lists
`timescale 1ns/1ns
`include "ms7200_defs.svh"

module cmd_table import ms7200_pkg::*; (
    input  logic       clk,
    input  logic       rstn_out,
    input  seq_state_t cur_state,
    input  cmd_index_t cur_index,
    output i2c_word_t  i2c_data,
    output logic       i2c_rh_wl
);

    i2c_word_t entry;
    i2c_op_t   op;

    assign op = (cur_state == SEQ_POLL || cur_state == SEQ_DECIDE) ? OP_READ : OP_WRITE;

    always_comb begin
        case (cur_state)
            SEQ_STARTUP, SEQ_INIT: begin
                case (cur_index)
                    5'd0:    entry = {16'h0003, 8'h5A};
                    5'd1:    entry = {16'h0204, 8'h02};
                    5'd2:    entry = {16'h0205, 8'h40};
                    5'd3:    entry = {16'h0004, 8'h01};
                    5'd4:    entry = {16'h0009, 8'h26};
                    5'd5:    entry = {16'h102E, 8'h01};
                    5'd6:    entry = {16'h1025, 8'hB0};
                    5'd7:    entry = {16'h102D, 8'h83};
                    5'd8:    entry = {16'h1000, 8'h20};
                    5'd9:    entry = {16'h100F, 8'h04};
                    5'd10:   entry = {16'h0003, 8'hC3};
                    5'd11:   entry = {16'h103B, 8'h02};
                    // Closing writes
                    5'd12:   entry = {16'h000C, 8'h00};
                    5'd13:   entry = {16'h000A, 8'h04};
                    5'd14:   entry = {16'h2000, 8'h0F};
                    5'd15:   entry = {16'h2001, 8'h00};
                    5'd16:   entry = {16'h2002, 8'h00};
                    5'd17:   entry = {16'h2003, 8'h01};
                    default: entry = {16'h0003, 8'h5A};
                endcase
            end
            SEQ_POLL, SEQ_DECIDE: begin
                case (cur_index)
                    5'd0:    entry = {16'h209C, 8'h00};   // Frequency byte 0
                    5'd1:    entry = {16'h209D, 8'h00};
                    5'd2:    entry = {16'h209E, 8'h00};
                    5'd3:    entry = {16'h209F, 8'h00};   // Holds clock status
                    default: entry = {16'h209C, 8'h00};
                endcase
            end
            default: begin
                // Receiver reset
                case (cur_index)
                    5'd0:    entry = {16'h1010, 8'h01};
                    5'd1:    entry = {16'h1024, 8'h00};
                    5'd2:    entry = {16'h0200, 8'h00};
                    5'd3:    entry = {16'h1024, 8'h70};
                    5'd4:    entry = {16'h0200, 8'h07};
                    5'd5:    entry = {16'h0215, 8'h01};
                    5'd6:    entry = {16'h0215, 8'h00};
                    default: entry = {16'h0003, 8'h5A};
                endcase
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            i2c_data  <= '0;
            i2c_rh_wl <= 1'b1;
        end else begin
            i2c_data  <= entry;
            i2c_rh_wl <= (op == OP_READ);
        end
    end

endmodule

//--- hdl/freq_monitor.sv
// Frequency monitor that assembles the polled bytes and detects receiver clock arrival
`timescale 1ns/1ns
`include "ms7200_defs.svh"

module freq_monitor import ms7200_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn_out,
    input  logic                 byte_valid,
    input  logic [1:0]           byte_sel,
    input  logic [`MS_DATA_W-1:0] rd_byte,
    input  logic                 poll_end,
    output logic                 freq_lock
);

    freq_word_t cur_word;    // Reading being assembled
    freq_word_t prev_word;   // Reading of the previous poll
    logic [1:0] cur_status;
    logic [1:0] prev_status;

    // ----------------------------------------------------------
    // Byte assembly
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            cur_word <= '0;
        end else if (byte_valid) begin
            if (byte_sel == 2'd0) begin
                cur_word <= freq_word_t'(rd_byte);   // Low lane starts a new word
            end else begin
                cur_word[byte_sel*`MS_DATA_W +: `MS_DATA_W] <= rd_byte;
            end
        end
    end

    // ----------------------------------------------------------
    // Previous reading
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            prev_word <= '0;
        end else if (poll_end) begin
            // After a detection the next arrival must again start from 00
            if (freq_lock) begin
                prev_word <= '0;
            end else begin
                prev_word <= cur_word;
            end
        end
    end

    assign cur_status  = cur_word[`MS_LOCK_HI:`MS_LOCK_LO];
    assign prev_status = prev_word[`MS_LOCK_HI:`MS_LOCK_LO];

    // Clock absent before, present now
    assign freq_lock = (prev_status == 2'b00) && (cur_status == 2'b10);

endmodule

//--- hdl/ms7200_cfg_top.sv
// Top level of the MS7200 power-up configuration sequencer
`timescale 1ns/1ns
`include "ms7200_defs.svh"

module ms7200_cfg_top import ms7200_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn_out,
    input  logic                  i2c_done,
    input  logic [`MS_DATA_W-1:0] i2c_data_r,
    output logic                  i2c_exec,
    output i2c_word_t             i2c_data,
    output logic                  i2c_rh_wl,
    output logic                  init_done
);

    logic       start_pulse;
    seq_state_t cur_state;
    cmd_index_t cur_index;
    logic       byte_valid;
    logic [1:0] byte_sel;
    logic       poll_end;
    logic       freq_lock;

    startup_timer u_startup_timer (
        .clk         (clk),
        .rstn_out    (rstn_out),
        .start_pulse (start_pulse)
    );

    freq_monitor u_freq_monitor (
        .clk        (clk),
        .rstn_out   (rstn_out),
        .byte_valid (byte_valid),
        .byte_sel   (byte_sel),
        .rd_byte    (i2c_data_r),
        .poll_end   (poll_end),
        .freq_lock  (freq_lock)
    );

    cfg_sequencer u_cfg_sequencer (
        .clk         (clk),
        .rstn_out    (rstn_out),
        .start_pulse (start_pulse),
        .i2c_done    (i2c_done),
        .freq_lock   (freq_lock),
        .i2c_exec    (i2c_exec),
        .cur_state   (cur_state),
        .cur_index   (cur_index),
        .byte_valid  (byte_valid),
        .byte_sel    (byte_sel),
        .poll_end    (poll_end),
        .init_done   (init_done)
    );

    cmd_table u_cmd_table (
        .clk       (clk),
        .rstn_out  (rstn_out),
        .cur_state (cur_state),
        .cur_index (cur_index),
        .i2c_data  (i2c_data),
        .i2c_rh_wl (i2c_rh_wl)
    );

endmodule

//--- hdl/ms7200_pkg.sv
// Shared types for the MS7200 configuration sequencer
`include "ms7200_defs.svh"

package ms7200_pkg;

    // Sequencer states
    typedef enum logic [2:0] {
        SEQ_STARTUP,
        SEQ_INIT,
        SEQ_POLL,
        SEQ_DECIDE,
        SEQ_RESET
    } seq_state_t;

    // I2C operation, encoded as the read/write level
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } i2c_op_t;

    typedef logic [`MS_INDEX_W-1:0]            cmd_index_t;
    typedef logic [`MS_ADDR_W+`MS_DATA_W-1:0]  i2c_word_t;   // {addr, data}
    typedef logic [`MS_FREQ_W-1:0]             freq_word_t;

endpackage

//--- hdl/startup_timer.sv
// Start-up timer that pulses once when the power-up wait after reset ends
`timescale 1ns/1ns
`include "ms7200_defs.svh"

module startup_timer (
    input  logic clk,
    input  logic rstn_out,
    output logic start_pulse
);

    logic [`MS_STARTUP_W-1:0] wait_cnt;

    // Saturates at the end of the wait
    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            wait_cnt <= '0;
        end else if (wait_cnt != `MS_STARTUP_W'(`MS_STARTUP_CYCLES)) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Single pulse on the last count, idle afterwards
    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= (wait_cnt == `MS_STARTUP_W'(`MS_STARTUP_CYCLES - 1));
        end
    end

endmodule

//--- include/ms7200_defs.svh
// Sizes, list lengths and bit positions for the MS7200 configuration sequencer
`ifndef MS7200_DEFS_SVH
`define MS7200_DEFS_SVH

// ----------------------------------------------------------
// Start-up wait
// ----------------------------------------------------------
`define MS_STARTUP_CYCLES 5000      // 5 ms at the 1 MHz clock
`define MS_STARTUP_W      13        // Holds the full wait count

// ----------------------------------------------------------
// Command lists
// ----------------------------------------------------------
`define MS_INIT_LEN  18             // Setup writes plus closing writes
`define MS_POLL_LEN  4              // Frequency byte reads
`define MS_RESET_LEN 7              // Receiver reset writes
`define MS_INDEX_W   5

// ----------------------------------------------------------
// I2C word and frequency reading
// ----------------------------------------------------------
`define MS_ADDR_W  16
`define MS_DATA_W  8
`define MS_FREQ_W  32

// Clock status field inside the frequency word
`define MS_LOCK_HI 25
`define MS_LOCK_LO 24

`endif

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and search the output for the pass line
verilator --binary --timing --assert -f verilog.f --top-module tb_ms7200_cfg -o tb_sim \
    && ./obj_dir/tb_sim | awk '{ print } $0 == "TB PASSED" { ok = 1 } END { exit !ok }' \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

//--- testbench/ms7200_cfg_assert.sv
// Concurrent checks on the sequencer exec handshake, init_done and poll byte capture
`timescale 1ns/1ns

module ms7200_cfg_assert import ms7200_pkg::*; (
    input logic       clk,
    input logic       rstn_out,
    input logic       i2c_exec,
    input logic       i2c_done,
    input logic       init_done,
    input logic       byte_valid,
    input seq_state_t cur_state
);

    logic busy;   // Command issued, done not yet back

    always_ff @(posedge clk or negedge rstn_out) begin
        if (!rstn_out) begin
            busy <= 1'b0;
        end else if (i2c_exec) begin
            busy <= 1'b1;
        end else if (i2c_done) begin
            busy <= 1'b0;
        end
    end

    // ----------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------
    exec_single: assert property (@(posedge clk) disable iff (!rstn_out)
        i2c_exec |=> !i2c_exec)
        else $error("exec high on two consecutive cycles");

    exec_waits_done: assert property (@(posedge clk) disable iff (!rstn_out)
        busy |-> !i2c_exec)
        else $error("exec issued while a command was still in flight");

    // ----------------------------------------------------------
    // Status
    // ----------------------------------------------------------
    init_done_sticky: assert property (@(posedge clk) disable iff (!rstn_out)
        init_done |=> init_done)
        else $error("init_done fell");

    byte_in_poll: assert property (@(posedge clk) disable iff (!rstn_out)
        byte_valid |-> (cur_state == SEQ_POLL))
        else $error("byte_valid outside of polling");

endmodule

//--- testbench/tb_ms7200_cfg.sv
// Testbench for the MS7200 configuration sequencer with a random I2C responder and list model
`timescale 1ns/1ns
`include "ms7200_defs.svh"

module tb_ms7200_cfg import ms7200_pkg::*;;

    localparam int LIST_INIT  = 0;
    localparam int LIST_POLL  = 1;
    localparam int LIST_RESET = 2;
    localparam int EXEC_LIMIT = 20;   // Cycles from a done to the next exec
    localparam int CMD_BUDGET = `MS_INIT_LEN + `MS_RESET_LEN * 2 + `MS_POLL_LEN * 12 + 12;
    localparam int WATCHDOG_NS = (`MS_STARTUP_CYCLES + 4 + CMD_BUDGET * 10) * 10;

    logic                  clk;
    logic                  rstn_out;
    logic                  i2c_done;
    logic [`MS_DATA_W-1:0] i2c_data_r;
    logic                  i2c_exec;
    i2c_word_t             i2c_data;
    logic                  i2c_rh_wl;
    logic                  init_done;

    logic [15:0] lfsr_state;
    int          err_cnt;
    int          test_pass;
    int          test_fail;
    int          cycle_cnt;
    int          exp_list;
    int          exp_index;
    int          exp_gap;
    logic        exp_init_done;
    logic [1:0]  prev_status;
    freq_word_t  poll_word;
    int          poll_cnt;
    int          resets_started;
    int          resets_done;
    logic        aborted;
    int          t_err;
    int          waited;

    ms7200_cfg_top uut (
        .clk        (clk),
        .rstn_out   (rstn_out),
        .i2c_done   (i2c_done),
        .i2c_data_r (i2c_data_r),
        .i2c_exec   (i2c_exec),
        .i2c_data   (i2c_data),
        .i2c_rh_wl  (i2c_rh_wl),
        .init_done  (init_done)
    );

    bind cfg_sequencer ms7200_cfg_assert u_seq_assert (
        .clk        (clk),
        .rstn_out   (rstn_out),
        .i2c_exec   (i2c_exec),
        .i2c_done   (i2c_done),
        .init_done  (init_done),
        .byte_valid (byte_valid),
        .cur_state  (cur_state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the sequence did not complete", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // Random source and reference lists
    // ----------------------------------------------------------
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Status field of each poll, stays 10 after the script
    function automatic logic [1:0] scripted_status(input int p);
        case (p)
            0:       return 2'b00;
            1:       return 2'b01;
            2, 3:    return 2'b10;
            4:       return 2'b00;
            default: return 2'b10;
        endcase
    endfunction

    function automatic i2c_word_t expected_word(input int list, input int idx);
        i2c_word_t init_list [0:17];
        i2c_word_t reset_list [0:6];
        init_list = '{{16'h0003, 8'h5A}, {16'h0204, 8'h02}, {16'h0205, 8'h40},
                      {16'h0004, 8'h01}, {16'h0009, 8'h26}, {16'h102E, 8'h01},
                      {16'h1025, 8'hB0}, {16'h102D, 8'h83}, {16'h1000, 8'h20},
                      {16'h100F, 8'h04}, {16'h0003, 8'hC3}, {16'h103B, 8'h02},
                      {16'h000C, 8'h00}, {16'h000A, 8'h04}, {16'h2000, 8'h0F},
                      {16'h2001, 8'h00}, {16'h2002, 8'h00}, {16'h2003, 8'h01}};
        reset_list = '{{16'h1010, 8'h01}, {16'h1024, 8'h00}, {16'h0200, 8'h00},
                       {16'h1024, 8'h70}, {16'h0200, 8'h07}, {16'h0215, 8'h01},
                       {16'h0215, 8'h00}};
        if (list == LIST_INIT) begin
            return init_list[idx];
        end else if (list == LIST_POLL) begin
            return {16'h209C + 16'(idx), 8'h00};
        end
        return reset_list[idx];
    endfunction

    // ----------------------------------------------------------
    // Cycle helpers
    // ----------------------------------------------------------
    task automatic step();
        @(posedge clk);
        #1;
        cycle_cnt++;
        if (init_done !== exp_init_done) begin
            $display("ERR %0t init_done expected %b actual %b", $time, exp_init_done, init_done);
            err_cnt++;
        end
    endtask

    task automatic wait_exec(input int limit, output int count);
        count = 0;
        while (i2c_exec !== 1'b1 && count < limit) begin
            step();
            count++;
        end
        if (i2c_exec !== 1'b1) begin
            $display("No exec from the DUT within %0d cycles at %0t", limit, $time);
            err_cnt++;
            aborted = 1'b1;
        end
    endtask

    task automatic compare_command();
        i2c_word_t exp_word;
        logic      exp_rw;
        exp_word = expected_word(exp_list, exp_index);
        exp_rw   = (exp_list == LIST_POLL) ? 1'b1 : 1'b0;   // Reads only while polling
        if (i2c_data !== exp_word) begin
            $display("ERR %0t i2c_data expected %h actual %h", $time, exp_word, i2c_data);
            err_cnt++;
        end
        if (i2c_rh_wl !== exp_rw) begin
            $display("ERR %0t i2c_rh_wl expected %b actual %b", $time, exp_rw, i2c_rh_wl);
            err_cnt++;
        end
    endtask

    // Answer the exec in flight, advance the model, then check the next exec
    task automatic complete_command();
        logic [31:0] r;
        logic [1:0]  cur_status;
        logic        lock;
        int          i;
        int          count;
        if (exp_list == LIST_POLL && exp_index == 0) begin
            poll_word = rand_bits(32);
            poll_word[`MS_LOCK_HI:`MS_LOCK_LO] = scripted_status(poll_cnt);
        end
        r = rand_bits(3);
        for (i = 0; i < 1 + r; i++) begin
            step();
            if (i2c_exec !== 1'b0) begin
                $display("Second exec at %0t before the done of the previous command", $time);
                err_cnt++;
            end
        end
        i2c_done = 1'b1;
        if (exp_list == LIST_POLL) begin
            i2c_data_r = poll_word[exp_index*`MS_DATA_W +: `MS_DATA_W];
        end else begin
            r = rand_bits(8);
            i2c_data_r = r[7:0];
        end
        exp_gap = 0;
        exp_index++;
        case (exp_list)
            LIST_INIT: begin
                if (exp_index == `MS_INIT_LEN) begin
                    exp_list  = LIST_POLL;
                    exp_index = 0;
                end
            end
            LIST_POLL: begin
                if (exp_index == `MS_POLL_LEN) begin
                    cur_status = poll_word[`MS_LOCK_HI:`MS_LOCK_LO];
                    lock = (prev_status == 2'b00) && (cur_status == 2'b10);
                    exp_gap   = 1;   // Decide cycle
                    exp_index = 0;
                    poll_cnt++;
                    if (lock) begin
                        prev_status = 2'b00;
                        exp_list    = LIST_RESET;
                        resets_started++;
                    end else begin
                        prev_status = cur_status;
                    end
                end
            end
            default: begin
                if (exp_index == `MS_RESET_LEN) begin
                    exp_list      = LIST_POLL;
                    exp_index     = 0;
                    exp_init_done = 1'b1;
                    resets_done++;
                end
            end
        endcase
        step();
        i2c_done   = 1'b0;
        i2c_data_r = '0;
        wait_exec(EXEC_LIMIT, count);
        if (!aborted) begin
            if (count != exp_gap) begin
                $display("ERR %0t exec_gap expected %0d actual %0d", $time, exp_gap, count);
                err_cnt++;
            end
            compare_command();
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            $display("Test %s: ok", name);
            test_pass++;
        end else begin
            $display("Test %s: %0d errors", name, err_cnt - err_before);
            test_fail++;
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        rstn_out       = 1'b0;
        i2c_done       = 1'b0;
        i2c_data_r     = '0;
        lfsr_state     = 16'd39273;
        err_cnt        = 0;
        test_pass      = 0;
        test_fail      = 0;
        cycle_cnt      = 0;
        exp_list       = LIST_INIT;
        exp_index      = 0;
        exp_gap        = 0;
        exp_init_done  = 1'b0;
        prev_status    = 2'b00;
        poll_word      = '0;
        poll_cnt       = 0;
        resets_started = 0;
        resets_done    = 0;
        aborted        = 1'b0;
        repeat (4) @(posedge clk);
        #1 rstn_out = 1'b1;

        t_err = err_cnt;
        wait_exec(`MS_STARTUP_CYCLES + EXEC_LIMIT, waited);
        if (!aborted) begin
            if (waited < `MS_STARTUP_CYCLES) begin
                $display("Exec after only %0d cycles, before the start-up wait ended", waited);
                err_cnt++;
            end else if (waited != `MS_STARTUP_CYCLES + 1) begin
                $display("ERR %0t first_exec_cycle expected %0d actual %0d", $time,
                         `MS_STARTUP_CYCLES + 1, waited);
                err_cnt++;
            end
            compare_command();
        end
        report_test("start-up wait and first command", t_err);

        t_err = err_cnt;
        while (exp_list == LIST_INIT && !aborted) begin
            complete_command();
        end
        report_test("initialisation writes", t_err);

        t_err = err_cnt;
        while (resets_started == 0 && !aborted) begin
            complete_command();
        end
        report_test("polling without false trigger", t_err);

        t_err = err_cnt;
        while (resets_done == 0 && !aborted) begin
            complete_command();
        end
        if (init_done !== 1'b1) begin
            $display("ERR %0t init_done expected 1 actual %b", $time, init_done);
            err_cnt++;
        end
        report_test("receiver reset list and init_done", t_err);

        t_err = err_cnt;
        while (resets_done < 2 && !aborted) begin
            complete_command();
        end
        report_test("second arrival and resumed polling", t_err);

        $display("Tests ok %0d, failed %0d, errors %0d, cycles %0d",
                 test_pass, test_fail, err_cnt, cycle_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hdl/ms7200_pkg.sv
hdl/startup_timer.sv
hdl/freq_monitor.sv
hdl/cfg_sequencer.sv
hdl/cmd_table.sv
hdl/ms7200_cfg_top.sv
testbench/ms7200_cfg_assert.sv
testbench/tb_ms7200_cfg.sv
